// File: verilog/opn_pkg.sv
/*
 * Definitions shared by the OPN control core. Holds the part-0 register map,
 * the bus write and DAC setting payloads, and the timer and sample types.
 * Imported by wildcard in every module header that needs it
 */
package opn_pkg;

    // Part-0 register addresses that the core still decodes
    localparam logic [7:0] REG_TIMER_A_HI = 8'h24; // Value A bits 9..2
    localparam logic [7:0] REG_TIMER_A_LO = 8'h25; // Value A bits 1..0
    localparam logic [7:0] REG_TIMER_B    = 8'h26;
    localparam logic [7:0] REG_TIMER_CTL  = 8'h27; // Load, IRQ enable, flag reset
    localparam logic [7:0] REG_DAC_DATA   = 8'h2A;
    localparam logic [7:0] REG_DAC_EN     = 8'h2B; // Bit 7 only
    localparam logic [7:0] REG_PAN_CH6    = 8'hB6; // Bit 7 left, bit 6 right

    // Timer counter and period values
    typedef logic [9:0] opn_timer_a_t;
    typedef logic [7:0] opn_timer_b_t;

    // One audio sample per side
    typedef logic signed [15:0] opn_sample_t;

    // Register write from the bus port to the decoder
    typedef struct packed {
        logic       wr;   // One-cycle strobe
        logic [7:0] addr;
        logic [7:0] data;
    } opn_reg_wr_t;

    // Channel 6 DAC settings
    typedef struct packed {
        logic [7:0] data;  // Offset binary, 0x80 is silence
        logic       en;
        logic       left;
        logic       right;
    } opn_dac_cfg_t;

endpackage

// File: verilog/opn_timer_if.sv
/*
 * Control link between the register decoder and one timer.
 * The counter type is a parameter so timer A and timer B share it
 */
`timescale 1ns/1ns

interface opn_timer_if #(
    parameter type cnt_t = logic [7:0]
);
    cnt_t value;     // Reload value
    logic load;      // Level, high while the timer runs
    logic irq_en;
    logic clr_flag;  // One-cycle pulse
    logic flag;

    modport regs (
        output value, load, irq_en, clr_flag,
        input  flag
    );

    modport timer (
        input  value, load, irq_en, clr_flag,
        output flag
    );
endinterface

// File: verilog/opn_clock_div.sv
/*
 * Prescaler. Divides cen into the internal operating enable, then that
 * enable into the one-cycle sample tick used by the timers and the DAC
 */
`timescale 1ns/1ns

module opn_clock_div #(
    parameter int CEN_DIV    = 6,
    parameter int SAMPLE_DIV = 24
) (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    output logic clk_en,
    output logic tick
);

    localparam int CW = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;
    localparam int TW = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

    logic [CW-1:0] cen_cnt;
    logic [TW-1:0] smp_cnt;

    assign clk_en = cen && cen_cnt == CW'(CEN_DIV - 1);
    assign tick   = clk_en && smp_cnt == TW'(SAMPLE_DIV - 1);  // Last enable of a sample

    always_ff @(posedge clk) begin
        if (rst) begin
            cen_cnt <= '0;
            smp_cnt <= '0;
        end else begin
            if (clk_en) cen_cnt <= '0;
            else if (cen) cen_cnt <= cen_cnt + 1'b1;
            if (tick) smp_cnt <= '0;
            else if (clk_en) smp_cnt <= smp_cnt + 1'b1;
        end
    end

endmodule

// File: verilog/opn_cpu_port.sv
/*
 * CPU bus port. Latches the register address, issues data writes to the
 * decoder, keeps the busy flag and drives the status byte and irq_n
 */
`timescale 1ns/1ns

module opn_cpu_port import opn_pkg::*; #(
    parameter int BUSY_LEN = 32
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        clk_en,
    input  logic [7:0]  din,
    input  logic [1:0]  addr,
    input  logic        cs_n,
    input  logic        wr_n,
    input  logic        flag_a,
    input  logic        flag_b,
    output opn_reg_wr_t reg_wr,
    output logic [7:0]  dout,
    output logic        irq_n
);

    localparam int BW = (BUSY_LEN > 1) ? $clog2(BUSY_LEN) : 1;
    localparam int SW = $clog2(BUSY_LEN + 1);

    logic          addr_wr, data_wr;
    logic [7:0]    reg_addr;
    logic          wr_stb;
    logic [7:0]    wr_addr, wr_data;
    logic          busy;
    logic [BW-1:0] busy_cnt;
    logic [SW-1:0] ce_since_wr;  // Enables seen since the last data write
    logic [7:0]    status;

    // Part 1 (addr[1] set) is not implemented
    assign addr_wr = !cs_n && !wr_n && !addr[1] && !addr[0];
    assign data_wr = !cs_n && !wr_n && !addr[1] &&  addr[0];

    always_ff @(posedge clk) begin
        if (addr_wr) reg_addr <= din;
        wr_addr <= reg_addr;
        wr_data <= din;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_stb      <= 1'b0;
            busy        <= 1'b0;
            busy_cnt    <= '0;
            ce_since_wr <= '0;
            status      <= 8'h00;
            irq_n       <= 1'b1;
        end else begin
            wr_stb <= data_wr;
            if (data_wr) begin
                busy     <= 1'b1;  // Restarts even if already busy
                busy_cnt <= '0;
            end else if (busy && clk_en) begin
                if (busy_cnt == BW'(BUSY_LEN - 1)) busy <= 1'b0;
                else busy_cnt <= busy_cnt + 1'b1;
            end
            if (data_wr) ce_since_wr <= '0;
            else if (clk_en && ce_since_wr != SW'(BUSY_LEN)) ce_since_wr <= ce_since_wr + 1'b1;
            status <= {busy, 5'b0, flag_b, flag_a};
            irq_n  <= ~(flag_a | flag_b);
        end
    end

    assign reg_wr = '{wr: wr_stb, addr: wr_addr, data: wr_data};
    assign dout   = status;

    // Busy must drop by the BUSY_LEN-th enable after the last data write
    a_busy_len: assert property (@(posedge clk) disable iff (rst)
        busy |-> ce_since_wr < SW'(BUSY_LEN));

endmodule

// File: verilog/opn_regs.sv
/*
 * Part-0 register decoder. Holds the timer values and control bits and
 * the channel 6 DAC settings, and turns the flag reset bits into pulses
 */
`timescale 1ns/1ns

module opn_regs import opn_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  opn_reg_wr_t  reg_wr,
    opn_timer_if.regs    tmr_a,
    opn_timer_if.regs    tmr_b,
    output opn_dac_cfg_t dac_cfg
);

    logic [7:0]   val_a_hi;
    logic [1:0]   val_a_lo;
    opn_timer_b_t val_b;
    logic         load_a, load_b;
    logic         irq_en_a, irq_en_b;
    logic         clr_a, clr_b;
    logic         ctl_wr;

    assign ctl_wr = reg_wr.wr && reg_wr.addr == REG_TIMER_CTL;

    // Timer periods
    always_ff @(posedge clk) begin
        if (reg_wr.wr) begin
            case (reg_wr.addr)
                REG_TIMER_A_HI: val_a_hi <= reg_wr.data;
                REG_TIMER_A_LO: val_a_lo <= reg_wr.data[1:0];
                REG_TIMER_B:    val_b    <= reg_wr.data;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            load_a   <= 1'b0;
            load_b   <= 1'b0;
            irq_en_a <= 1'b0;
            irq_en_b <= 1'b0;
            clr_a    <= 1'b0;
            clr_b    <= 1'b0;
            dac_cfg  <= '{data: 8'h80, en: 1'b0, left: 1'b1, right: 1'b1};
        end else begin
            clr_a <= ctl_wr && reg_wr.data[4];  // Flag reset A
            clr_b <= ctl_wr && reg_wr.data[5];
            if (ctl_wr) begin
                load_a   <= reg_wr.data[0];
                load_b   <= reg_wr.data[1];
                irq_en_a <= reg_wr.data[2];
                irq_en_b <= reg_wr.data[3];
            end
            if (reg_wr.wr) begin
                case (reg_wr.addr)
                    REG_DAC_DATA: dac_cfg.data <= reg_wr.data;
                    REG_DAC_EN:   dac_cfg.en   <= reg_wr.data[7];
                    REG_PAN_CH6: begin
                        dac_cfg.left  <= reg_wr.data[7];
                        dac_cfg.right <= reg_wr.data[6];
                    end
                    default: ;
                endcase
            end
        end
    end

    assign tmr_a.value    = {val_a_hi, val_a_lo};
    assign tmr_a.load     = load_a;
    assign tmr_a.irq_en   = irq_en_a;
    assign tmr_a.clr_flag = clr_a;

    assign tmr_b.value    = val_b;
    assign tmr_b.load     = load_b;
    assign tmr_b.irq_en   = irq_en_b;
    assign tmr_b.clr_flag = clr_b;

endmodule

// File: verilog/opn_timer.sv
/*
 * One OPN timer. Counts up from its reload value every PRESCALE sample
 * ticks while load is held, reloads at the top and raises its flag
 */
`timescale 1ns/1ns

module opn_timer import opn_pkg::*; #(
    parameter type cnt_t    = opn_timer_b_t,
    parameter int  PRESCALE = 1
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    opn_timer_if.timer ctl
);

    localparam int PW = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

    cnt_t          cnt;
    logic [PW-1:0] pre_cnt;
    logic          load_q;
    logic          start;
    logic          step;
    logic          ovf;

    assign start = ctl.load && !load_q;  // Rising edge of load
    assign step  = ctl.load && !start && tick && pre_cnt == PW'(PRESCALE - 1);
    assign ovf   = step && cnt == '1;

    always_ff @(posedge clk) begin
        if (start) cnt <= ctl.value;
        else if (step) cnt <= ovf ? ctl.value : cnt_t'(cnt + 1'b1);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            load_q   <= 1'b0;
            pre_cnt  <= '0;
            ctl.flag <= 1'b0;
        end else begin
            load_q <= ctl.load;
            if (start || !ctl.load) pre_cnt <= '0;
            else if (tick) pre_cnt <= (pre_cnt == PW'(PRESCALE - 1)) ? '0 : pre_cnt + 1'b1;
            if (ovf && ctl.irq_en) ctl.flag <= 1'b1;
            else if (ctl.clr_flag) ctl.flag <= 1'b0;  // Held until reset by the CPU
        end
    end

    // The flag only rises from an overflow with IRQ enabled
    a_flag_irq_en: assert property (@(posedge clk) disable iff (rst)
        $rose(ctl.flag) |-> $past(ctl.irq_en));

endmodule

// File: verilog/opn_dac.sv
/*
 * Channel 6 DAC. Converts the offset-binary byte to a signed sample at
 * each tick, applies left/right panning and strobes snd_sample
 */
`timescale 1ns/1ns

module opn_dac import opn_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         tick,
    input  opn_dac_cfg_t cfg,
    output opn_sample_t  snd_left,
    output opn_sample_t  snd_right,
    output logic         snd_sample
);

    logic signed [7:0] pcm;  // data - 128
    opn_sample_t       smp;

    assign pcm = {~cfg.data[7], cfg.data[6:0]};
    // Scale by 64 with sign extension
    assign smp = cfg.en ? opn_sample_t'({{2{pcm[7]}}, pcm, 6'b0}) : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            snd_left   <= '0;
            snd_right  <= '0;
            snd_sample <= 1'b0;
        end else begin
            snd_sample <= tick;
            if (tick) begin
                snd_left  <= cfg.left  ? smp : '0;
                snd_right <= cfg.right ? smp : '0;
            end
        end
    end

endmodule

// File: verilog/opn_top.sv
/*
 * Top level of the OPN control core. Wires the prescaler, CPU port,
 * part-0 registers, both timers and the channel 6 DAC together
 */
`timescale 1ns/1ns

module opn_top import opn_pkg::*; #(
    parameter int CEN_DIV    = 6,   // cen pulses per internal enable
    parameter int SAMPLE_DIV = 24,  // Internal enables per sample
    parameter int BUSY_LEN   = 32   // Internal enables per busy period
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic [7:0]  din,
    input  logic [1:0]  addr,
    input  logic        cs_n,
    input  logic        wr_n,

    output logic [7:0]  dout,
    output logic        irq_n,
    output opn_sample_t snd_left,
    output opn_sample_t snd_right,
    output logic        snd_sample
);

    logic         clk_en;
    logic         tick;     // One per output sample
    opn_reg_wr_t  reg_wr;
    opn_dac_cfg_t dac_cfg;

    opn_timer_if #(.cnt_t(opn_timer_a_t)) tmr_a ();
    opn_timer_if #(.cnt_t(opn_timer_b_t)) tmr_b ();

    opn_clock_div #(.CEN_DIV(CEN_DIV), .SAMPLE_DIV(SAMPLE_DIV)) u_clock_div (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .cen    ( cen    ),
        .clk_en ( clk_en ),
        .tick   ( tick   )
    );

    // Bus cycles only count while the external enable is high
    opn_cpu_port #(.BUSY_LEN(BUSY_LEN)) u_cpu_port (
        .clk    ( clk         ),
        .rst    ( rst         ),
        .clk_en ( clk_en      ),
        .din    ( din         ),
        .addr   ( addr        ),
        .cs_n   ( cs_n | ~cen ),
        .wr_n   ( wr_n        ),
        .flag_a ( tmr_a.flag  ),
        .flag_b ( tmr_b.flag  ),
        .reg_wr ( reg_wr      ),
        .dout   ( dout        ),
        .irq_n  ( irq_n       )
    );

    opn_regs u_regs (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .reg_wr  ( reg_wr  ),
        .tmr_a   ( tmr_a   ),
        .tmr_b   ( tmr_b   ),
        .dac_cfg ( dac_cfg )
    );

    opn_timer #(.cnt_t(opn_timer_a_t), .PRESCALE(1)) u_timer_a (
        .clk  ( clk   ),
        .rst  ( rst   ),
        .tick ( tick  ),
        .ctl  ( tmr_a )
    );

    // Timer B advances once every 16 samples
    opn_timer #(.cnt_t(opn_timer_b_t), .PRESCALE(16)) u_timer_b (
        .clk  ( clk   ),
        .rst  ( rst   ),
        .tick ( tick  ),
        .ctl  ( tmr_b )
    );

    opn_dac u_dac (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .tick       ( tick       ),
        .cfg        ( dac_cfg    ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample )
    );

endmodule

// File: tests/opn_checker.sv
/*
 * Output checker for the OPN control core testbench. Started by req with
 * a check code and expected values, watches dout, irq_n and the sound
 * outputs on the falling edge, prints one line per test and counts errors
 */
`timescale 1ns/1ns

module opn_checker import opn_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  dout,
    input  logic        irq_n,
    input  opn_sample_t snd_left,
    input  opn_sample_t snd_right,
    input  logic        snd_sample,
    input  logic        req,
    input  int          test_id,
    input  logic [3:0]  code,
    input  logic [7:0]  mask,
    input  logic [7:0]  value,
    input  int          lo,       // Earliest cycle, or settle time for sound checks
    input  int          hi,       // Window length in cycles
    input  opn_sample_t exp_l,
    input  opn_sample_t exp_r,
    output int          done_cnt,
    output int          err_cnt
);

    localparam logic [3:0] CHK_RESET  = 4'd1;
    localparam logic [3:0] CHK_STATUS = 4'd2;  // Masked status reaches value in [lo, hi]
    localparam logic [3:0] CHK_HOLD   = 4'd3;  // Masked status stays at value for hi cycles
    localparam logic [3:0] CHK_IRQ    = 4'd4;
    localparam logic [3:0] CHK_SND    = 4'd5;

    function automatic string code_name(input logic [3:0] c);
        case (c)
            CHK_RESET:  return "reset state";
            CHK_STATUS: return "status change";
            CHK_HOLD:   return "status hold";
            CHK_IRQ:    return "irq_n level";
            CHK_SND:    return "sound sample";
            default:    return "unknown";
        endcase
    endfunction

    task automatic run_check();
        int n;
        int pulses;
        int errs_before;
        bit finished;
        bit hit;
        bit was_high;
        n = 0;
        pulses = 0;
        errs_before = err_cnt;
        finished = 0;
        was_high = 0;
        while (!finished) begin
            case (code)
                CHK_RESET: begin
                    if (dout !== 8'h00 || irq_n !== 1'b1 ||
                        snd_left !== '0 || snd_right !== '0) begin
                        $display("Error at %0t ns: test %0d dout 0x%02h irq_n %b left %0d right %0d",
                                 $time, test_id, dout, irq_n, snd_left, snd_right);
                        err_cnt++;
                        finished = 1;
                    end else if (snd_sample === 1'b1 && was_high) begin
                        $display("Test %0d: snd_sample stayed high for more than one cycle",
                                 test_id);
                        err_cnt++;
                        finished = 1;
                    end
                    if (snd_sample === 1'b1) pulses++;
                    was_high = (snd_sample === 1'b1);
                    if (!finished && n >= hi) begin
                        if (pulses < 2) begin
                            $display("Test %0d: snd_sample pulsed only %0d times after reset",
                                     test_id, pulses);
                            err_cnt++;
                        end
                        finished = 1;
                    end
                end
                CHK_STATUS, CHK_IRQ: begin
                    hit = (code == CHK_STATUS) ? ((dout & mask) === value) : (irq_n === value[0]);
                    if (hit && n < lo) begin
                        $display("Test %0d: output changed after %0d cycles, earlier than %0d",
                                 test_id, n, lo);
                        err_cnt++;
                    end else if (!hit && n >= hi) begin
                        $display("Test %0d: expected output not seen within %0d cycles",
                                 test_id, hi);
                        err_cnt++;
                    end
                    finished = hit || n >= hi;
                end
                CHK_HOLD: begin
                    if ((dout & mask) !== value) begin
                        $display("Error at %0t ns: test %0d status %02h, expected %02h mask %02h",
                                 $time, test_id, dout, value, mask);
                        err_cnt++;
                        finished = 1;
                    end else if (n >= hi) finished = 1;
                end
                CHK_SND: begin
                    // Pulses before lo may carry old settings
                    if (snd_sample === 1'b1 && n >= lo) begin
                        if (snd_left !== exp_l || snd_right !== exp_r) begin
                            $display("Error at %0t ns: test %0d left %0d right %0d, expected %0d %0d",
                                     $time, test_id, snd_left, snd_right, exp_l, exp_r);
                            err_cnt++;
                        end
                        finished = 1;
                    end else if (n >= hi) begin
                        $display("Test %0d: no snd_sample pulse within %0d cycles", test_id, hi);
                        err_cnt++;
                        finished = 1;
                    end
                end
                default: begin
                    $display("Test %0d: unknown check code %0d", test_id, code);
                    err_cnt++;
                    finished = 1;
                end
            endcase
            if (!finished) begin
                @(negedge clk);
                n++;
            end
        end
        $display("Test %0d %s: %s", test_id, code_name(code),
                 (err_cnt == errs_before) ? "passed" : "FAILED");
        done_cnt++;
    endtask

    initial begin
        done_cnt = 0;
        err_cnt  = 0;
        forever begin
            @(negedge clk);
            if (req && !rst) run_check();
        end
    end

endmodule

// File: tests/opn_top_tb.sv
/*
 * Testbench for the OPN control core. Walks a table of bus writes and
 * expected results, hands each check to opn_checker and waits for it
 */
`timescale 1ns/1ns

module opn_top_tb import opn_pkg::*; ();

    localparam logic [1:0] BUS_NONE = 2'd0;
    localparam logic [1:0] BUS_P0   = 2'd1;
    localparam logic [1:0] BUS_P1   = 2'd2;  // Upper bank, addr[1] set

    localparam logic [3:0] CHK_NONE   = 4'd0;
    localparam logic [3:0] CHK_RESET  = 4'd1;
    localparam logic [3:0] CHK_STATUS = 4'd2;
    localparam logic [3:0] CHK_HOLD   = 4'd3;
    localparam logic [3:0] CHK_IRQ    = 4'd4;
    localparam logic [3:0] CHK_SND    = 4'd5;

    localparam int SAMPLE = 144;  // Cycles per sample with cen high (6 * 24)

    typedef struct packed {
        logic [1:0]  bus;
        logic [7:0]  ra;
        logic [7:0]  data;
        logic [3:0]  code;
        logic [7:0]  mask;
        logic [7:0]  value;
        int          lo;
        int          hi;     // Check window, or idle cycles for CHK_NONE
        opn_sample_t exp_l;
        opn_sample_t exp_r;
    } row_t;

    logic        clk, rst, cen, cs_n, wr_n;
    logic [7:0]  din, dout;
    logic [1:0]  addr;
    logic        irq_n, snd_sample;
    opn_sample_t snd_left, snd_right;

    logic        req;
    int          chk_id, chk_lo, chk_hi;
    logic [3:0]  chk_code;
    logic [7:0]  chk_mask, chk_value;
    opn_sample_t chk_exp_l, chk_exp_r;
    int          done_cnt, err_cnt;
    int          cycles = 0;
    int          limit = 0;
    integer      seed = 69;
    row_t        rows[$];

    opn_top #(.CEN_DIV(6), .SAMPLE_DIV(24), .BUSY_LEN(32)) opn_top_inst (
        .clk(clk), .rst(rst), .cen(cen), .din(din), .addr(addr), .cs_n(cs_n), .wr_n(wr_n),
        .dout(dout), .irq_n(irq_n), .snd_left(snd_left), .snd_right(snd_right),
        .snd_sample(snd_sample)
    );

    opn_checker out_check (
        .clk(clk), .rst(rst), .dout(dout), .irq_n(irq_n), .snd_left(snd_left),
        .snd_right(snd_right), .snd_sample(snd_sample), .req(req), .test_id(chk_id),
        .code(chk_code), .mask(chk_mask), .value(chk_value), .lo(chk_lo), .hi(chk_hi),
        .exp_l(chk_exp_l), .exp_r(chk_exp_r), .done_cnt(done_cnt), .err_cnt(err_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    function automatic void add_row(input logic [1:0] bus, input logic [7:0] ra,
                                    input logic [7:0] data, input logic [3:0] code,
                                    input logic [7:0] mask, input logic [7:0] value,
                                    input int lo, input int hi,
                                    input opn_sample_t exp_l, input opn_sample_t exp_r);
        row_t r;
        r = '{bus, ra, data, code, mask, value, lo, hi, exp_l, exp_r};
        rows.push_back(r);
    endfunction

    function automatic void build_table();
        logic [7:0]  d;
        logic [7:0]  pan;
        opn_sample_t s;
        add_row(BUS_NONE, 8'h00, 8'h00, CHK_RESET, 8'h00, 8'h00, 0, 3 * SAMPLE + 20, '0, '0);
        // Busy rises 2 cycles after the write, falls after 32 enables
        add_row(BUS_P0, REG_DAC_EN, 8'h00, CHK_STATUS, 8'h80, 8'h80, 0, 2, '0, '0);
        add_row(BUS_NONE, 8'h00, 8'h00, CHK_STATUS, 8'h80, 8'h00, 176, 196, '0, '0);
        // Timer A at 1020 overflows on the 4th tick
        add_row(BUS_P0, REG_TIMER_A_HI, 8'hFF, CHK_NONE, 8'h00, 8'h00, 0, 2, '0, '0);
        add_row(BUS_P0, REG_TIMER_A_LO, 8'h00, CHK_NONE, 8'h00, 8'h00, 0, 2, '0, '0);
        add_row(BUS_P0, REG_TIMER_CTL, 8'h05, CHK_STATUS, 8'h01, 8'h01, 412, 600, '0, '0);
        add_row(BUS_NONE, 8'h00, 8'h00, CHK_IRQ, 8'h00, 8'h00, 0, 4, '0, '0);
        add_row(BUS_P0, REG_TIMER_CTL, 8'h10, CHK_STATUS, 8'h01, 8'h00, 0, 8, '0, '0);
        add_row(BUS_NONE, 8'h00, 8'h00, CHK_IRQ, 8'h00, 8'h01, 0, 4, '0, '0);
        // Timer B at 255 overflows after one count of 16 ticks
        add_row(BUS_P0, REG_TIMER_B, 8'hFF, CHK_NONE, 8'h00, 8'h00, 0, 2, '0, '0);
        add_row(BUS_P0, REG_TIMER_CTL, 8'h0A, CHK_STATUS, 8'h02, 8'h02, 2140, 2334, '0, '0);
        add_row(BUS_P0, REG_TIMER_CTL, 8'h20, CHK_STATUS, 8'h02, 8'h00, 0, 8, '0, '0);
        add_row(BUS_P0, REG_TIMER_CTL, 8'h02, CHK_HOLD, 8'h02, 8'h00, 0, 40 * SAMPLE, '0, '0);
        add_row(BUS_P0, REG_TIMER_CTL, 8'h00, CHK_NONE, 8'h00, 8'h00, 0, 2, '0, '0);
        for (int k = 0; k < 4; k++) begin
            d = 8'($random(seed));
            s = opn_sample_t'((int'(d) - 128) * 64);  // Offset binary, scaled by 64
            pan = 8'(k << 6);  // Neither, right only, left only, then both
            add_row(BUS_P0, REG_DAC_DATA, d, CHK_NONE, 8'h00, 8'h00, 0, 2, '0, '0);
            add_row(BUS_P0, REG_DAC_EN, 8'h80, CHK_NONE, 8'h00, 8'h00, 0, 2, '0, '0);
            add_row(BUS_P0, REG_PAN_CH6, pan, CHK_SND, 8'h00, 8'h00, 8, SAMPLE + 20,
                    pan[7] ? s : '0, pan[6] ? s : '0);
        end
        add_row(BUS_P0, REG_DAC_EN, 8'h00, CHK_SND, 8'h00, 8'h00, 8, SAMPLE + 20, '0, '0);
        add_row(BUS_P0, REG_DAC_EN, 8'h80, CHK_SND, 8'h00, 8'h00, 8, SAMPLE + 20, s, s);
        add_row(BUS_P1, REG_DAC_DATA, ~d, CHK_SND, 8'h00, 8'h00, 8, SAMPLE + 20, s, s);
    endfunction

    // Address write, then data write in the next cycle
    task automatic bus_write(input logic [1:0] base, input logic [7:0] ra,
                             input logic [7:0] data);
        @(posedge clk);
        cs_n <= 1'b0;
        wr_n <= 1'b0;
        addr <= base;
        din  <= ra;
        @(posedge clk);
        addr <= base | 2'b01;
        din  <= data;
        @(posedge clk);
        cs_n <= 1'b1;
        wr_n <= 1'b1;
    endtask

    initial begin
        int sent;
        rst = 1'b1;
        cen = 1'b1;
        din = 8'h00;
        addr = 2'b00;
        cs_n = 1'b1;
        wr_n = 1'b1;
        req = 1'b0;
        chk_id = 0;
        chk_code = CHK_NONE;
        chk_mask = 8'h00;
        chk_value = 8'h00;
        chk_lo = 0;
        chk_hi = 0;
        chk_exp_l = '0;
        chk_exp_r = '0;
        sent = 0;
        build_table();
        foreach (rows[i]) limit += rows[i].hi;
        limit += 2000;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        foreach (rows[i]) begin
            if (rows[i].bus == BUS_NONE) @(posedge clk);
            else bus_write((rows[i].bus == BUS_P1) ? 2'b10 : 2'b00, rows[i].ra, rows[i].data);
            if (rows[i].code == CHK_NONE) begin
                repeat (rows[i].hi) @(posedge clk);
            end else begin
                req       <= 1'b1;
                chk_id    <= i + 1;
                chk_code  <= rows[i].code;
                chk_mask  <= rows[i].mask;
                chk_value <= rows[i].value;
                chk_lo    <= rows[i].lo;
                chk_hi    <= rows[i].hi;
                chk_exp_l <= rows[i].exp_l;
                chk_exp_r <= rows[i].exp_r;
                sent++;
                @(posedge clk);
                req <= 1'b0;
                while (done_cnt < sent) @(posedge clk);  // Watchdog bounds this wait
            end
        end
        $display("Tests run: %0d, errors: %0d", done_cnt, err_cnt);
        if (err_cnt == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // Watchdog
    initial begin
        @(posedge clk);
        while (cycles < limit) @(posedge clk);
        $display("Timeout: the run reached %0d cycles before the last test finished", limit);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: opn_top.f
verilog/opn_pkg.sv
verilog/opn_timer_if.sv
verilog/opn_clock_div.sv
verilog/opn_cpu_port.sv
verilog/opn_regs.sv
verilog/opn_timer.sv
verilog/opn_dac.sv
verilog/opn_top.sv
tests/opn_checker.sv
tests/opn_top_tb.sv

// File: Makefile
# Verilator build and run of the OPN control core testbench

TOP := opn_top_tb

.PHONY: all lint clean

# Build, run, and pass only if the pass line shows up in the output
all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f opn_top.f -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

lint:
	verilator --lint-only --timing --top-module opn_top -f opn_top.f

clean:
	rm -rf obj_dir
